// File: sources.f
loadBufferPkg.sv
lbEntryArray.sv
lbOrderCheck.sv
lbLateIssue.sv
loadBuffer.sv
tbLoadBuffer.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the load buffer testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tbLoadBuffer -o simLoadBuffer &&
  ./obj_dir/simLoadBuffer | tee /dev/stderr | grep -x "TEST PASS" > /dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// File: tbLoadBuffer.sv
`timescale 1ns/1ns

module tbLoadBuffer import loadBufferPkg::*; ();

  // Tests take about 850 ns and the bounded late waits can add 600 ns more
  localparam int watchdogNs = 2000;
  localparam int lateWaitCycles = 20;

  logic clk, rst;
  logic uopValid, uopIsLoad, uopIsStore, uopEarlyFail;
  logic [addrWidth-1:0] uopAddr;
  AccessSize uopSize;
  logic [sqnWidth-1:0] uopSqN, uopLoadSqN, comLoadSqN;
  logic sqDone, ackValid, ackFail, branchTaken, branchFlush, lateReady;
  logic [sqnWidth-1:0] ackLoadSqN, branchSqN, branchLoadSqN;
  logic lateValid, lateIsMmio, rbValid;
  logic [addrWidth-1:0] lateAddr;
  AccessSize lateSize;
  logic [sqnWidth-1:0] lateSqN, lateLoadSqN, rbSqN, rbLoadSqN, maxLoadSqN;
  int errorCount = 0;
  int checkCount = 0;

  loadBuffer UUT (.*);

  always #5 clk = ~clk;

  initial begin
    #(watchdogNs);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  task automatic compareValue(string name, logic [31:0] got, logic [31:0] expected);
    checkCount++;
    assert (got === expected) else begin
      errorCount++;
      $display("Fail %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic driveUop(logic valid, logic isLoad, logic [31:0] addr, AccessSize size,
                          logic [7:0] sqN, logic [7:0] ldSqN, logic earlyFail);
    uopValid     <= valid;
    uopIsLoad    <= valid && isLoad;
    uopIsStore   <= valid && !isLoad;
    uopAddr      <= addr;
    uopSize      <= size;
    uopSqN       <= sqN;
    uopLoadSqN   <= ldSqN;
    uopEarlyFail <= earlyFail;
  endtask

  task automatic sendLoad(logic [7:0] sqN, logic [7:0] ldSqN, logic [31:0] addr,
                          AccessSize size, logic earlyFail);
    @(posedge clk);
    driveUop(1'b1, 1'b1, addr, size, sqN, ldSqN, earlyFail);
    @(posedge clk);
    driveUop(1'b0, 1'b0, addr, size, sqN, ldSqN, 1'b0);
  endtask

  // Store for one cycle with a rollback expected only in the following cycle
  task automatic sendStore(logic [7:0] sqN, logic [7:0] ldSqN, logic [31:0] addr,
                           AccessSize size, logic expectRb);
    @(posedge clk);
    driveUop(1'b1, 1'b0, addr, size, sqN, ldSqN, 1'b0);
    @(negedge clk);
    compareValue("rbValid", rbValid, 1'b0);
    @(posedge clk);
    driveUop(1'b0, 1'b0, addr, size, sqN, ldSqN, 1'b0);
    @(negedge clk);
    compareValue("rbValid", rbValid, expectRb);
    if (expectRb) begin
      compareValue("rbSqN", rbSqN, sqN);
      compareValue("rbLoadSqN", rbLoadSqN, ldSqN);
    end
    @(negedge clk);
    compareValue("rbValid", rbValid, 1'b0);
  endtask

  task automatic waitLate();
    int cycles = 0;
    @(negedge clk);
    while (!lateValid && cycles < lateWaitCycles) begin
      @(negedge clk);
      cycles++;
    end
    checkCount++;
    assert (lateValid) else begin
      errorCount++;
      $display("Late issue did not arrive within %0d cycles", lateWaitCycles);
    end
  endtask

  task automatic lateMatches(logic [31:0] addr, AccessSize size, logic [7:0] sqN,
                             logic [7:0] ldSqN, logic mmio);
    compareValue("lateAddr", lateAddr, addr);
    compareValue("lateSize", lateSize, size);
    compareValue("lateSqN", lateSqN, sqN);
    compareValue("lateLoadSqN", lateLoadSqN, ldSqN);
    compareValue("lateIsMmio", lateIsMmio, mmio);
  endtask

  task automatic expectNoLate(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      checkCount++;
      assert (!lateValid) else begin
        errorCount++;
        $display("Load %h was late-issued although it must wait or was dropped", lateLoadSqN);
      end
    end
  endtask

  task automatic setHead(logic [7:0] head);
    @(posedge clk);
    comLoadSqN <= head;
    @(posedge clk);
  endtask

  task automatic resetAndWindow();
    @(negedge clk);
    compareValue("lateValid", lateValid, 1'b0);
    compareValue("rbValid", rbValid, 1'b0);
    @(posedge clk);
    comLoadSqN <= 8'h10;
    // Window limit lags the head by one cycle
    @(negedge clk);
    compareValue("maxLoadSqN", maxLoadSqN, 8'h07);
    @(negedge clk);
    compareValue("maxLoadSqN", maxLoadSqN, 8'h17);
  endtask

  task automatic reissueBackPressure();
    logic [31:0] addr;
    addr = 32'h0000_2000 + 32'(2 * ($urandom % 2));
    @(posedge clk);
    lateReady <= 1'b0;
    sendLoad(8'h40, 8'h10, addr, sizeHalf, 1'b1);
    waitLate();
    lateMatches(addr, sizeHalf, 8'h40, 8'h10, 1'b0);
    repeat (3) begin
      @(negedge clk);
      compareValue("lateValid", lateValid, 1'b1);
      lateMatches(addr, sizeHalf, 8'h40, 8'h10, 1'b0);
    end
    @(posedge clk);
    lateReady <= 1'b1;
    @(posedge clk);
    ackValid   <= 1'b1;
    ackFail    <= 1'b1;
    ackLoadSqN <= 8'h10;
    @(negedge clk);
    compareValue("lateValid", lateValid, 1'b0);
    @(posedge clk);
    ackValid <= 1'b0;
    ackFail  <= 1'b0;
    // Nacked load comes back on the late path
    waitLate();
    lateMatches(addr, sizeHalf, 8'h40, 8'h10, 1'b0);
  endtask

  task automatic orderViolation();
    logic [1:0] lane;
    logic [1:0] nextLane;
    logic [31:0] loadAddr;
    lane = 2'($urandom % 4);
    nextLane = lane + 2'd1;
    loadAddr = 32'h0000_3000 + 32'(lane);
    setHead(8'h18);
    sendLoad(8'h48, 8'h18, 32'h0000_4000, sizeWord, 1'b0);
    sendLoad(8'h50, 8'h19, loadAddr, sizeByte, 1'b0);
    sendStore(8'h4c, 8'h19, loadAddr, sizeByte, 1'b1);
    sendStore(8'h46, 8'h18, 32'h0000_4002, sizeHalf, 1'b1);
    // Neighbouring byte in the same word
    sendStore(8'h4c, 8'h19, 32'h0000_3000 + 32'(nextLane), sizeByte, 1'b0);
    // Only the older load overlaps
    sendStore(8'h4c, 8'h19, 32'h0000_4000, sizeWord, 1'b0);
  endtask

  task automatic mmioInOrder();
    setHead(8'h20);
    sendLoad(8'h60, 8'h21, 32'h8000_0010, sizeWord, 1'b0);
    // Stores drained but the load is not the oldest yet
    expectNoLate(6);
    @(posedge clk);
    sqDone <= 1'b0;
    setHead(8'h21);
    expectNoLate(6);
    @(posedge clk);
    sqDone <= 1'b1;
    waitLate();
    lateMatches(32'h8000_0010, sizeWord, 8'h60, 8'h21, 1'b1);
  endtask

  task automatic invalidation();
    logic [31:0] hitAddr;
    hitAddr = 32'h0000_7000 + 32'($urandom % 4);
    setHead(8'h28);
    @(posedge clk);
    lateReady <= 1'b0;
    // Oldest load sits in the output register while the next one waits
    sendLoad(8'h70, 8'h28, 32'h0000_6000, sizeWord, 1'b1);
    sendLoad(8'h78, 8'h2a, 32'h0000_6004, sizeWord, 1'b1);
    sendLoad(8'h7a, 8'h2b, hitAddr, sizeByte, 1'b0);
    @(posedge clk);
    branchTaken   <= 1'b1;
    branchSqN     <= 8'h74;
    branchLoadSqN <= 8'h2a;
    @(posedge clk);
    branchTaken <= 1'b0;
    @(negedge clk);
    compareValue("lateValid", lateValid, 1'b1);
    compareValue("lateLoadSqN", lateLoadSqN, 8'h28);
    @(posedge clk);
    lateReady <= 1'b1;
    @(posedge clk);
    expectNoLate(8);
    sendStore(8'h72, 8'h2a, hitAddr, sizeByte, 1'b0);
    // Commit drops an issued load the same way
    sendLoad(8'h7c, 8'h2c, 32'h0000_7100, sizeWord, 1'b0);
    sendStore(8'h6e, 8'h2c, 32'h0000_7100, sizeWord, 1'b1);
    setHead(8'h2d);
    sendStore(8'h6e, 8'h2c, 32'h0000_7100, sizeWord, 1'b0);
  endtask

  initial begin
    void'($urandom(32'hfb0b6507));
    clk = 1'b0;
    rst = 1'b1;
    comLoadSqN = '0;
    sqDone = 1'b1;
    ackValid = 1'b0;
    ackFail = 1'b0;
    ackLoadSqN = '0;
    branchTaken = 1'b0;
    branchFlush = 1'b0;
    branchSqN = '0;
    branchLoadSqN = '0;
    lateReady = 1'b1;
    driveUop(1'b0, 1'b0, '0, sizeByte, '0, '0, 1'b0);
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    resetAndWindow();
    reissueBackPressure();
    orderViolation();
    mmioInOrder();
    invalidation();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: loadBuffer.sv
`timescale 1ns/1ns

module loadBuffer import loadBufferPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 uopValid,
  input  logic                 uopIsLoad,
  input  logic                 uopIsStore,
  input  logic [addrWidth-1:0] uopAddr,
  input  AccessSize            uopSize,
  input  logic [sqnWidth-1:0]  uopSqN,
  input  logic [sqnWidth-1:0]  uopLoadSqN,
  input  logic                 uopEarlyFail,
  input  logic [sqnWidth-1:0]  comLoadSqN,
  input  logic                 sqDone,
  input  logic                 ackValid,
  input  logic                 ackFail,
  input  logic [sqnWidth-1:0]  ackLoadSqN,
  input  logic                 branchTaken,
  input  logic                 branchFlush,
  input  logic [sqnWidth-1:0]  branchSqN,
  input  logic [sqnWidth-1:0]  branchLoadSqN,
  input  logic                 lateReady,
  output logic                 lateValid,
  output logic [addrWidth-1:0] lateAddr,
  output AccessSize            lateSize,
  output logic [sqnWidth-1:0]  lateSqN,
  output logic [sqnWidth-1:0]  lateLoadSqN,
  output logic                 lateIsMmio,
  output logic                 rbValid,
  output logic [sqnWidth-1:0]  rbSqN,
  output logic [sqnWidth-1:0]  rbLoadSqN,
  output logic [sqnWidth-1:0]  maxLoadSqN
);

  logic [lbEntries-1:0]  entryValid;
  logic [lbEntries-1:0]  entryIssued;
  logic [lbEntries-1:0]  entryNonSpec;
  logic [addrWidth-1:0]  entryAddr [lbEntries-1:0];
  AccessSize             entrySize [lbEntries-1:0];
  logic [sqnWidth-1:0]   entrySqN [lbEntries-1:0];
  logic                  issueValid;
  logic [lbIdxWidth-1:0] issueIdx;

  lbEntryArray entries (
    .clk, .rst,
    .uopValid, .uopIsLoad, .uopAddr, .uopSize, .uopSqN, .uopLoadSqN, .uopEarlyFail,
    .comLoadSqN, .ackValid, .ackFail, .ackLoadSqN,
    .branchTaken, .branchFlush, .branchSqN, .branchLoadSqN,
    .issueValid, .issueIdx,
    .entryValid, .entryIssued, .entryNonSpec, .entryAddr, .entrySize, .entrySqN,
    .maxLoadSqN
  );

  lbOrderCheck orderCheck (
    .clk, .rst,
    .uopValid, .uopIsStore, .uopAddr, .uopSize, .uopSqN, .uopLoadSqN,
    .comLoadSqN, .branchTaken, .branchSqN,
    .entryValid, .entryIssued, .entryAddr, .entrySize,
    .rbValid, .rbSqN, .rbLoadSqN
  );

  lbLateIssue lateIssue (
    .clk, .rst,
    .comLoadSqN, .sqDone, .branchTaken, .branchFlush, .branchSqN,
    .entryValid, .entryIssued, .entryNonSpec, .entryAddr, .entrySize, .entrySqN,
    .lateReady,
    .issueValid, .issueIdx,
    .lateValid, .lateAddr, .lateSize, .lateSqN, .lateLoadSqN, .lateIsMmio
  );

endmodule

// File: lbLateIssue.sv
`timescale 1ns/1ns

module lbLateIssue import loadBufferPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [sqnWidth-1:0]   comLoadSqN,
  input  logic                  sqDone,
  input  logic                  branchTaken,
  input  logic                  branchFlush,
  input  logic [sqnWidth-1:0]   branchSqN,
  input  logic [lbEntries-1:0]  entryValid,
  input  logic [lbEntries-1:0]  entryIssued,
  input  logic [lbEntries-1:0]  entryNonSpec,
  input  logic [addrWidth-1:0]  entryAddr [lbEntries-1:0],
  input  AccessSize             entrySize [lbEntries-1:0],
  input  logic [sqnWidth-1:0]   entrySqN [lbEntries-1:0],
  input  logic                  lateReady,
  output logic                  issueValid,
  output logic [lbIdxWidth-1:0] issueIdx,
  output logic                  lateValid,
  output logic [addrWidth-1:0]  lateAddr,
  output AccessSize             lateSize,
  output logic [sqnWidth-1:0]   lateSqN,
  output logic [sqnWidth-1:0]   lateLoadSqN,
  output logic                  lateIsMmio
);

  logic [lbIdxWidth-1:0] headIdx;
  logic [lbIdxWidth-1:0] scanIdx;
  logic [lbIdxWidth-1:0] selIdx;
  logic [lbEntries-1:0]  candidate;
  logic                  selValid;
  logic                  mmioReady;
  logic                  regFree;

  assign headIdx   = comLoadSqN[lbIdxWidth-1:0];
  assign candidate = entryValid & ~entryIssued & ~entryNonSpec;

  // MMIO only goes once it is the oldest load and stores have drained
  assign mmioReady = entryValid[headIdx] && !entryIssued[headIdx] &&
                     entryNonSpec[headIdx] && sqDone;

  always_comb begin
    selValid = 1'b0;
    selIdx   = headIdx;
    scanIdx  = headIdx;
    // Oldest speculative candidate, counting from the head
    for (int k = 0; k < lbEntries; k++) begin
      scanIdx = headIdx + lbIdxWidth'(k);
      if (!selValid && candidate[scanIdx]) begin
        selValid = 1'b1;
        selIdx   = scanIdx;
      end
    end
    if (mmioReady) begin
      selValid = 1'b1;
      selIdx   = headIdx;
    end
  end

  assign regFree    = !lateValid || lateReady;
  assign issueValid = selValid && regFree && !branchTaken;
  assign issueIdx   = selIdx;

  always_ff @(posedge clk) begin
    if (rst) begin
      lateValid <= 1'b0;
    end else begin
      if (lateReady)
        lateValid <= 1'b0;
      if (branchTaken) begin
        // Wrong-path load in the output register is dropped
        if (branchFlush || isYounger(lateSqN, branchSqN))
          lateValid <= 1'b0;
      end else if (issueValid) begin
        lateValid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issueValid) begin
      lateAddr    <= entryAddr[selIdx];
      lateSize    <= entrySize[selIdx];
      lateSqN     <= entrySqN[selIdx];
      lateLoadSqN <= loadSqNOf(selIdx, comLoadSqN);
      lateIsMmio  <= isMmio(entryAddr[selIdx]);
    end
  end

  lateHoldStable: assert property (
    @(posedge clk) disable iff (rst)
    lateValid && !lateReady && !branchTaken |=>
      lateValid && $stable(lateAddr) && $stable(lateSize) && $stable(lateSqN) &&
      $stable(lateLoadSqN) && $stable(lateIsMmio)
  ) else $error("Late load changed while held");

endmodule

// File: lbOrderCheck.sv
`timescale 1ns/1ns

module lbOrderCheck import loadBufferPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 uopValid,
  input  logic                 uopIsStore,
  input  logic [addrWidth-1:0] uopAddr,
  input  AccessSize            uopSize,
  input  logic [sqnWidth-1:0]  uopSqN,
  input  logic [sqnWidth-1:0]  uopLoadSqN,
  input  logic [sqnWidth-1:0]  comLoadSqN,
  input  logic                 branchTaken,
  input  logic [sqnWidth-1:0]  branchSqN,
  input  logic [lbEntries-1:0] entryValid,
  input  logic [lbEntries-1:0] entryIssued,
  input  logic [addrWidth-1:0] entryAddr [lbEntries-1:0],
  input  AccessSize            entrySize [lbEntries-1:0],
  output logic                 rbValid,
  output logic [sqnWidth-1:0]  rbSqN,
  output logic [sqnWidth-1:0]  rbLoadSqN
);

  logic [sqnWidth-1:0]  headQ;
  logic [lbEntries-1:0] inRange;
  logic [lbEntries-1:0] hit;
  logic [3:0]           storeMask;
  logic                 storeActive;
  logic                 conflict;

  // Array contents are still numbered against last cycle's head
  always_ff @(posedge clk) begin
    if (rst)
      headQ <= '0;
    else
      headQ <= comLoadSqN;
  end

  assign storeActive = uopValid && uopIsStore && !(branchTaken && isYounger(uopSqN, branchSqN));
  assign storeMask   = byteMask(uopSize, uopAddr[1:0]);

  always_comb begin
    for (int i = 0; i < lbEntries; i++) begin
      // Loads younger than the store have numbers at or above its loadSqN
      inRange[i] = !isYounger(uopLoadSqN, loadSqNOf(lbIdxWidth'(i), headQ));
      hit[i] = inRange[i] && entryValid[i] && entryIssued[i] &&
               (entryAddr[i][addrWidth-1:2] == uopAddr[addrWidth-1:2]) &&
               |(byteMask(entrySize[i], entryAddr[i][1:0]) & storeMask);
    end
    conflict = storeActive && |hit;
  end

  // Rollback goes back to the store itself
  always_ff @(posedge clk) begin
    if (rst)
      rbValid <= 1'b0;
    else
      rbValid <= conflict;
  end

  always_ff @(posedge clk) begin
    if (conflict) begin
      rbSqN     <= uopSqN;
      rbLoadSqN <= uopLoadSqN;
    end
  end

  rbFollowsStore: assert property (
    @(posedge clk) disable iff (rst)
    rbValid |-> $past(uopValid && uopIsStore)
  ) else $error("Rollback without a store in the previous cycle");

endmodule

// File: lbEntryArray.sv
`timescale 1ns/1ns

module lbEntryArray import loadBufferPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  uopValid,
  input  logic                  uopIsLoad,
  input  logic [addrWidth-1:0]  uopAddr,
  input  AccessSize             uopSize,
  input  logic [sqnWidth-1:0]   uopSqN,
  input  logic [sqnWidth-1:0]   uopLoadSqN,
  input  logic                  uopEarlyFail,
  input  logic [sqnWidth-1:0]   comLoadSqN,
  input  logic                  ackValid,
  input  logic                  ackFail,
  input  logic [sqnWidth-1:0]   ackLoadSqN,
  input  logic                  branchTaken,
  input  logic                  branchFlush,
  input  logic [sqnWidth-1:0]   branchSqN,
  input  logic [sqnWidth-1:0]   branchLoadSqN,
  input  logic                  issueValid,
  input  logic [lbIdxWidth-1:0] issueIdx,
  output logic [lbEntries-1:0]  entryValid,
  output logic [lbEntries-1:0]  entryIssued,
  output logic [lbEntries-1:0]  entryNonSpec,
  output logic [addrWidth-1:0]  entryAddr [lbEntries-1:0],
  output AccessSize             entrySize [lbEntries-1:0],
  output logic [sqnWidth-1:0]   entrySqN [lbEntries-1:0],
  output logic [sqnWidth-1:0]   maxLoadSqN
);

  logic [sqnWidth-1:0]   lastHead;
  logic [lbEntries-1:0]  commitMask;
  logic [lbEntries-1:0]  branchMask;
  logic [lbIdxWidth-1:0] insIdx;
  logic [lbIdxWidth-1:0] ackIdx;
  logic                  insertEn;
  logic                  newIsMmio;

  assign insIdx    = uopLoadSqN[lbIdxWidth-1:0];
  assign ackIdx    = ackLoadSqN[lbIdxWidth-1:0];
  assign newIsMmio = isMmio(uopAddr);

  // Loads on the wrong path of a taken branch are not recorded
  assign insertEn = uopValid && uopIsLoad && !(branchTaken && isYounger(uopSqN, branchSqN));

  always_comb begin
    for (int i = 0; i < lbEntries; i++) begin
      // Slots still hold numbers relative to the previous head
      commitMask[i] = isYounger(comLoadSqN, loadSqNOf(lbIdxWidth'(i), lastHead));
      // Everything at or after the branch load number goes
      branchMask[i] = branchTaken &&
                      (branchFlush ||
                       !isYounger(branchLoadSqN, loadSqNOf(lbIdxWidth'(i), comLoadSqN)));
    end
  end

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      entryValid   <= '0;
      entryIssued  <= '0;
      entryNonSpec <= '0;
      lastHead     <= '0;
    end else begin
      lastHead <= comLoadSqN;

      // Nacked loads must go through the late path again
      if (ackValid && ackFail)
        entryIssued[ackIdx] <= 1'b0;

      if (issueValid)
        entryIssued[issueIdx] <= 1'b1;

      entryValid <= entryValid & ~(commitMask | branchMask);

      // New load, later assignment wins over invalidation
      if (insertEn) begin
        entryValid[insIdx]   <= 1'b1;
        entryIssued[insIdx]  <= !(uopEarlyFail || newIsMmio);
        entryNonSpec[insIdx] <= newIsMmio;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (insertEn) begin
      entryAddr[insIdx] <= uopAddr;
      entrySize[insIdx] <= uopSize;
      entrySqN[insIdx]  <= uopSqN;
    end
  end

  // Highest load number the window can take
  always_ff @(posedge clk) begin
    maxLoadSqN <= comLoadSqN + sqnWidth'(lbEntries - 1);
  end

  // The dispatch limit keeps a load from landing on a live slot
  insertFreeSlot: assert property (
    @(posedge clk) disable iff (rst)
    insertEn |-> !entryValid[insIdx] || commitMask[insIdx] || branchMask[insIdx]
  ) else $error("Load %0d inserted over a valid entry", uopLoadSqN);

endmodule

// File: loadBufferPkg.sv
package loadBufferPkg;

  localparam int lbEntries = 8;
  localparam int lbIdxWidth = 3;
  localparam int sqnWidth = 8;
  localparam int addrWidth = 32;

  typedef enum logic [1:0] {
    sizeByte = 2'd0,
    sizeHalf = 2'd1,
    sizeWord = 2'd2
  } AccessSize;

  // Byte enables inside the 32-bit word
  function automatic logic [3:0] byteMask(AccessSize size, logic [1:0] addrLow);
    logic [3:0] mask;
    case (size)
      sizeByte: mask = 4'b0001 << addrLow;
      sizeHalf: mask = 4'b0011 << {addrLow[1], 1'b0};
      default:  mask = 4'b1111;
    endcase
    return mask;
  endfunction

  // True when a comes after b, wrap-safe
  function automatic logic isYounger(logic [sqnWidth-1:0] a, logic [sqnWidth-1:0] b);
    logic signed [sqnWidth-1:0] diff;
    diff = a - b;
    return diff > 0;
  endfunction

  // Upper half of the address space is MMIO
  function automatic logic isMmio(logic [addrWidth-1:0] addr);
    return addr[addrWidth-1];
  endfunction

  // Full load sequence number of a slot, relative to the window head
  function automatic logic [sqnWidth-1:0] loadSqNOf(logic [lbIdxWidth-1:0] idx,
                                                    logic [sqnWidth-1:0] head);
    logic [sqnWidth-lbIdxWidth-1:0] hiBits;
    hiBits = head[sqnWidth-1:lbIdxWidth];
    if (idx < head[lbIdxWidth-1:0])
      hiBits = hiBits + 1'b1;
    return {hiBits, idx};
  endfunction

endpackage
